// File: mem2rw_top.f
mem2rw_pkg.sv
dp_sram.sv
rw_port_pipe.sv
mem2rw_checker.sv
mem2rw_top.sv
mem2rw_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the simulation with Verilator, run it, and decide from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module mem2rw_tb -f mem2rw_top.f -o mem2rw_sim \
  && ./obj_dir/mem2rw_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Done: no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: mem2rw_tb.sv
`timescale 1ns/1ps

module mem2rw_tb;

  localparam int NUMADDR    = 1024;
  localparam int SRAM_DELAY = 1;
  localparam int FLOPIN     = 1;
  localparam int FLOPOUT    = 1;
  localparam int LAT        = FLOPIN + SRAM_DELAY + FLOPOUT;
  // the six tests take about 1800 cycles together.
  localparam int TIMEOUT_CYCLES = 6000;
  // base of the 64-word window that the tests work in.
  localparam logic [mem2rw_pkg::BITADDR-1:0] WIN = 10'h140;

  // each expected response falls due at the negedge where cyc equals its due field.
  typedef struct packed {
    int                           due;
    logic [mem2rw_pkg::WIDTH-1:0] known;
    mem2rw_pkg::rw_rsp_t          rsp;
  } pending_t;

  logic                           clk = 1'b0;
  logic                           rst;
  mem2rw_pkg::rw_req_t            req0;
  mem2rw_pkg::rw_req_t            req1;
  mem2rw_pkg::rw_rsp_t            rsp0;
  mem2rw_pkg::rw_rsp_t            rsp1;
  logic [mem2rw_pkg::BITADDR-1:0] select_addr;
  logic [mem2rw_pkg::BITWDTH-1:0] select_bit;

  logic [31:0] seed = 32'ha3e2cc03;
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          err_start = 0;

  logic [mem2rw_pkg::WIDTH-1:0] ref_mem   [NUMADDR];
  logic [mem2rw_pkg::WIDTH-1:0] ref_known [NUMADDR];
  pending_t                     pend0 [$];
  pending_t                     pend1 [$];

  mem2rw_top #(
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN),
    .FLOPOUT    (FLOPOUT)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .req0        (req0),
    .req1        (req1),
    .rsp0        (rsp0),
    .rsp1        (rsp1),
    .select_addr (select_addr),
    .select_bit  (select_bit)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic mem2rw_pkg::rw_req_t make_req(input logic rd, input logic wr,
      input logic [mem2rw_pkg::BITADDR-1:0] addr, input logic [mem2rw_pkg::WIDTH-1:0] din,
      input logic [mem2rw_pkg::WIDTH-1:0] bw);
    mem2rw_pkg::rw_req_t q;
    q.read  = rd;
    q.write = wr;
    q.addr  = addr;
    q.din   = din;
    q.bw    = bw;
    return q;
  endfunction

  // random idle, read or write inside the window where reads are as likely as idles.
  function automatic mem2rw_pkg::rw_req_t random_op();
    logic [31:0] r;
    logic [31:0] d;
    r = next_rand();
    d = next_rand();
    return make_req(r[31:30] == 2'd1, r[31], WIN + 10'(r[21:16]), d[31:16], d[15:0]);
  endfunction

  // expected read data is the reference word before this cycle's writes.
  function automatic mem2rw_pkg::rw_rsp_t expect_word(input logic [mem2rw_pkg::BITADDR-1:0] addr);
    mem2rw_pkg::rw_rsp_t e;
    e.vld  = 1'b1;
    e.dout = ref_mem[addr];
    return e;
  endfunction

  task automatic apply_write(input mem2rw_pkg::rw_req_t r);
    if (r.write) begin
      ref_mem[r.addr]   = (ref_mem[r.addr] & ~r.bw) | (r.din & r.bw);
      ref_known[r.addr] = ref_known[r.addr] | r.bw;
    end
  endtask

  task automatic drive_cycle(input mem2rw_pkg::rw_req_t r0, input mem2rw_pkg::rw_req_t r1);
    pending_t p;
    @(posedge clk);
    #1;
    if (r0.read) begin
      p.due   = cyc + LAT;
      p.known = ref_known[r0.addr];
      p.rsp   = expect_word(r0.addr);
      pend0.push_back(p);
    end
    if (r1.read) begin
      p.due   = cyc + LAT;
      p.known = ref_known[r1.addr];
      p.rsp   = expect_word(r1.addr);
      pend1.push_back(p);
    end
    // port 1 goes last so it wins where both masks are set.
    apply_write(r0);
    apply_write(r1);
    req0 = r0;
    req1 = r1;
  endtask

  task automatic check_vld(input int port, input mem2rw_pkg::rw_rsp_t got, input logic expected);
    checks++;
    if (got.vld !== expected) begin
      errors++;
      if (expected) $display("ERR %0t: port %0d valid strobe missing", $time, port);
      else $display("ERR %0t: port %0d unexpected valid strobe", $time, port);
    end
  endtask

  task automatic check_rsp(input int port, input mem2rw_pkg::rw_rsp_t got,
      input mem2rw_pkg::rw_rsp_t exp, input logic [mem2rw_pkg::WIDTH-1:0] known);
    checks++;
    if (((got.dout ^ exp.dout) & known) !== '0) begin
      errors++;
      $display("ERR %0t: port %0d read data %h, expected %h on bits %h",
               $time, port, got.dout, exp.dout, known);
    end
  endtask

  // ------------------------------
  // compare process
  // ------------------------------
  always @(negedge clk) begin : compare
    logic due0;
    logic due1;
    if (!rst) begin
      due0 = (pend0.size() != 0) && (pend0[0].due == cyc);
      due1 = (pend1.size() != 0) && (pend1[0].due == cyc);
      check_vld(0, rsp0, due0);
      check_vld(1, rsp1, due1);
      if (due0) begin
        if (rsp0.vld) check_rsp(0, rsp0, pend0[0].rsp, pend0[0].known);
        void'(pend0.pop_front());
      end
      if (due1) begin
        if (rsp1.vld) check_rsp(1, rsp1, pend1[0].rsp, pend1[0].known);
        void'(pend1.pop_front());
      end
    end
  end

  // the selected word gets a full write first so the checker shadows start known.
  task automatic begin_test(input logic [mem2rw_pkg::BITADDR-1:0] addr,
      input logic [mem2rw_pkg::BITWDTH-1:0] sel_bit);
    logic [31:0] r;
    err_start   = errors;
    select_addr = addr;
    select_bit  = sel_bit;
    r = next_rand();
    drive_cycle(make_req(1'b0, 1'b1, addr, r[31:16], 16'hffff), '0);
  endtask

  task automatic end_test(input int num, input string name);
    drive_cycle('0, '0);
    while (pend0.size() != 0 || pend1.size() != 0) drive_cycle('0, '0);
    repeat (2) drive_cycle('0, '0);
    if (errors == err_start) $display("test %0d %s: passed", num, name);
    else $display("test %0d %s: %0d errors", num, name, errors - err_start);
  endtask

  initial begin : stimulus
    logic [31:0] r;
    rst         = 1'b1;
    req0        = '0;
    req1        = '0;
    select_addr = '0;
    select_bit  = '0;
    for (int i = 0; i < NUMADDR; i++) ref_known[i] = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test(WIN + 10'd3, 4'd9);
    drive_cycle(make_req(1'b1, 1'b0, WIN + 10'd3, '0, '0), '0);
    drive_cycle('0, make_req(1'b1, 1'b0, WIN + 10'd3, '0, '0));
    end_test(1, "full write then read on both ports");

    // every bit of the new data differs from the old word.
    begin_test(WIN + 10'd7, 4'd3);
    drive_cycle(make_req(1'b0, 1'b1, WIN + 10'd7, ~ref_mem[WIN + 10'd7], 16'h3c5a), '0);
    drive_cycle(make_req(1'b1, 1'b0, WIN + 10'd7, '0, '0),
                make_req(1'b1, 1'b0, WIN + 10'd7, '0, '0));
    end_test(2, "partial write mask");

    // opposite data on the two ports so the winner shows on every shared bit.
    begin_test(WIN + 10'd12, 4'd5);
    r = next_rand();
    drive_cycle(make_req(1'b0, 1'b1, WIN + 10'd12, r[31:16], 16'h0ff0),
                make_req(1'b0, 1'b1, WIN + 10'd12, ~r[31:16], 16'h00ff));
    drive_cycle(make_req(1'b1, 1'b0, WIN + 10'd12, '0, '0),
                make_req(1'b1, 1'b0, WIN + 10'd12, '0, '0));
    end_test(3, "same-address write collision");

    begin_test(WIN + 10'd20, 4'd0);
    r = next_rand();
    drive_cycle(make_req(1'b1, 1'b0, WIN + 10'd20, '0, '0),
                make_req(1'b0, 1'b1, WIN + 10'd20, r[31:16], 16'hffff));
    drive_cycle(make_req(1'b0, 1'b1, WIN + 10'd20, r[15:0], 16'hffff),
                make_req(1'b1, 1'b0, WIN + 10'd20, '0, '0));
    drive_cycle(make_req(1'b1, 1'b0, WIN + 10'd20, '0, '0), '0);
    end_test(4, "read meets write on the other port");

    begin_test(WIN, 4'd15);
    for (int i = 0; i < 32; i++) begin
      r = next_rand();
      drive_cycle(make_req(1'b0, 1'b1, WIN + 10'(2 * i), r[31:16], 16'hffff),
                  make_req(1'b0, 1'b1, WIN + 10'(2 * i + 1), r[15:0], 16'hffff));
    end
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      drive_cycle(make_req(1'b1, 1'b0, WIN + 10'(r[29:24]), '0, '0),
                  make_req(1'b1, 1'b0, WIN + 10'(r[21:16]), '0, '0));
    end
    end_test(5, "back-to-back reads");

    begin_test(WIN + 10'd33, 4'd6);
    for (int i = 0; i < 1500; i++) drive_cycle(random_op(), random_op());
    end_test(6, "random read and write mix");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: mem2rw_top.sv
`timescale 1ns/1ps

module mem2rw_top #(
  parameter int NUMADDR    = 1024,
  parameter int SRAM_DELAY = 1,
  parameter int FLOPIN     = 1,
  parameter int FLOPOUT    = 1
) (
  input  logic                           clk,
  input  logic                           rst,
  input  mem2rw_pkg::rw_req_t            req0,
  input  mem2rw_pkg::rw_req_t            req1,
  output mem2rw_pkg::rw_rsp_t            rsp0,
  output mem2rw_pkg::rw_rsp_t            rsp1,
  input  logic [mem2rw_pkg::BITADDR-1:0] select_addr,
  input  logic [mem2rw_pkg::BITWDTH-1:0] select_bit
);

  mem2rw_pkg::sram_req_t        sram_a;
  mem2rw_pkg::sram_req_t        sram_b;
  logic [mem2rw_pkg::WIDTH-1:0] sram_a_dout;
  logic [mem2rw_pkg::WIDTH-1:0] sram_b_dout;

  // port 0 owns SRAM port a, port 1 owns SRAM port b.
  rw_port_pipe #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN),
    .FLOPOUT    (FLOPOUT)
  ) u_port0 (
    .clk       (clk),
    .rst       (rst),
    .req       (req0),
    .sram_req  (sram_a),
    .sram_dout (sram_a_dout),
    .rsp       (rsp0)
  );

  rw_port_pipe #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN),
    .FLOPOUT    (FLOPOUT)
  ) u_port1 (
    .clk       (clk),
    .rst       (rst),
    .req       (req1),
    .sram_req  (sram_b),
    .sram_dout (sram_b_dout),
    .rsp       (rsp1)
  );

  dp_sram #(
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_sram (
    .clk    (clk),
    .a_req  (sram_a),
    .b_req  (sram_b),
    .a_dout (sram_a_dout),
    .b_dout (sram_b_dout)
  );

  mem2rw_checker #(
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN),
    .FLOPOUT    (FLOPOUT)
  ) u_chk (
    .clk         (clk),
    .rst         (rst),
    .req0        (req0),
    .req1        (req1),
    .rsp0        (rsp0),
    .rsp1        (rsp1),
    .sram_a      (sram_a),
    .sram_b      (sram_b),
    .sram_a_dout (sram_a_dout),
    .sram_b_dout (sram_b_dout),
    .select_addr (select_addr),
    .select_bit  (select_bit)
  );

endmodule

// File: mem2rw_checker.sv
`timescale 1ns/1ps

module mem2rw_checker #(
  parameter int NUMADDR    = 1024,
  parameter int SRAM_DELAY = 1,
  parameter int FLOPIN     = 1,
  parameter int FLOPOUT    = 1
) (
  input logic                           clk,
  input logic                           rst,
  input mem2rw_pkg::rw_req_t            req0,
  input mem2rw_pkg::rw_req_t            req1,
  input mem2rw_pkg::rw_rsp_t            rsp0,
  input mem2rw_pkg::rw_rsp_t            rsp1,
  input mem2rw_pkg::sram_req_t          sram_a,
  input mem2rw_pkg::sram_req_t          sram_b,
  input logic [mem2rw_pkg::WIDTH-1:0]   sram_a_dout,
  input logic [mem2rw_pkg::WIDTH-1:0]   sram_b_dout,
  input logic [mem2rw_pkg::BITADDR-1:0] select_addr,
  input logic [mem2rw_pkg::BITWDTH-1:0] select_bit
);

  localparam int LATENCY = FLOPIN + SRAM_DELAY + FLOPOUT;

  mem2rw_pkg::rw_req_t          ext_req   [2];
  mem2rw_pkg::rw_rsp_t          ext_rsp   [2];
  mem2rw_pkg::sram_req_t        sram_req  [2];
  logic [mem2rw_pkg::WIDTH-1:0] sram_dout [2];

  // selected bit as last written at the SRAM ports, and at the external ports.
  logic mem_inv;
  logic mem_bit;
  logic ext_inv;
  logic ext_bit;

  assign ext_req[0]   = req0;
  assign ext_req[1]   = req1;
  assign ext_rsp[0]   = rsp0;
  assign ext_rsp[1]   = rsp1;
  assign sram_req[0]  = sram_a;
  assign sram_req[1]  = sram_b;
  assign sram_dout[0] = sram_a_dout;
  assign sram_dout[1] = sram_b_dout;

  // ------------------------------
  // shadow bits
  // ------------------------------
  // port 1 is visited last so it wins a same-cycle collision, as in the array.
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_inv <= 1'b1;
      ext_inv <= 1'b1;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (sram_req[p].write && sram_req[p].bw[select_bit] &&
            (sram_req[p].addr == select_addr)) begin
          mem_inv <= 1'b0;
          mem_bit <= sram_req[p].din[select_bit];
        end
        if (ext_req[p].write && ext_req[p].bw[select_bit] &&
            (ext_req[p].addr == select_addr)) begin
          ext_inv <= 1'b0;
          ext_bit <= ext_req[p].din[select_bit];
        end
      end
    end
  end

  // the SRAM side trails the external side by the input stage.
  if (FLOPIN != 0) begin : g_agree_dly
    a_shadow_agree: assert property (@(posedge clk) disable iff (rst)
      $past(ext_inv, FLOPIN) || (!mem_inv && (mem_bit == $past(ext_bit, FLOPIN))));
  end else begin : g_agree
    a_shadow_agree: assert property (@(posedge clk) disable iff (rst)
      ext_inv || (!mem_inv && (mem_bit == ext_bit)));
  end

  // ------------------------------
  // per-port read checks
  // ------------------------------
  for (genvar p = 0; p < 2; p++) begin : g_port
    a_ext_addr_range: assert property (@(posedge clk) disable iff (rst)
      (ext_req[p].read || ext_req[p].write) |-> (ext_req[p].addr < NUMADDR));

    a_sram_dout: assert property (@(posedge clk) disable iff (rst)
      (sram_req[p].read && (sram_req[p].addr == select_addr)) |-> ##SRAM_DELAY
      ($past(mem_inv, SRAM_DELAY) ||
       (sram_dout[p][select_bit] == $past(mem_bit, SRAM_DELAY))));

    a_rsp_dout: assert property (@(posedge clk) disable iff (rst)
      (ext_req[p].read && (ext_req[p].addr == select_addr)) |-> ##LATENCY
      ($past(ext_inv, LATENCY) ||
       (ext_rsp[p].vld && (ext_rsp[p].dout[select_bit] == $past(ext_bit, LATENCY)))));
  end

endmodule

// File: rw_port_pipe.sv
`timescale 1ns/1ps

module rw_port_pipe #(
  parameter int SRAM_DELAY = 1,
  parameter int FLOPIN     = 1,
  parameter int FLOPOUT    = 1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  mem2rw_pkg::rw_req_t          req,
  output mem2rw_pkg::sram_req_t        sram_req,
  input  logic [mem2rw_pkg::WIDTH-1:0] sram_dout,
  output mem2rw_pkg::rw_rsp_t          rsp
);

  // one bit per read still inside the SRAM, oldest at the top.
  logic [SRAM_DELAY-1:0] rd_track;
  logic                  sram_vld;

  // ------------------------------
  // input stage
  // ------------------------------
  if (FLOPIN != 0) begin : g_flopin
    always_ff @(posedge clk) begin
      sram_req <= mem2rw_pkg::sram_req_t'(req);
      if (rst) begin
        sram_req.read  <= 1'b0;
        sram_req.write <= 1'b0;
      end
    end
  end else begin : g_noflopin
    assign sram_req = mem2rw_pkg::sram_req_t'(req);
  end

  // ------------------------------
  // read tracking
  // ------------------------------
  // a read strobe enters at the bottom and leaves the top exactly when the
  // SRAM presents its data, so back-to-back reads each get their own pulse.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_track <= '0;
    end else begin
      rd_track <= (rd_track << 1) | SRAM_DELAY'(sram_req.read);
    end
  end

  assign sram_vld = rd_track[SRAM_DELAY-1];

  // ------------------------------
  // output stage
  // ------------------------------
  if (FLOPOUT != 0) begin : g_flopout
    always_ff @(posedge clk) begin
      rsp.dout <= sram_dout;
      if (rst) begin
        rsp.vld <= 1'b0;
      end else begin
        rsp.vld <= sram_vld;
      end
    end
  end else begin : g_noflopout
    assign rsp.vld  = sram_vld;
    assign rsp.dout = sram_dout;
  end

  // a port carries one access per cycle.
  a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(req.read && req.write));

endmodule

// File: dp_sram.sv
`timescale 1ns/1ps

module dp_sram #(
  parameter int NUMADDR    = 1024,
  parameter int SRAM_DELAY = 1
) (
  input  logic                         clk,
  input  mem2rw_pkg::sram_req_t        a_req,
  input  mem2rw_pkg::sram_req_t        b_req,
  output logic [mem2rw_pkg::WIDTH-1:0] a_dout,
  output logic [mem2rw_pkg::WIDTH-1:0] b_dout
);

  logic [mem2rw_pkg::WIDTH-1:0] mem [NUMADDR];
  mem2rw_pkg::sram_req_t        port_req [2];
  logic [mem2rw_pkg::WIDTH-1:0] rd_pipe [2][SRAM_DELAY];

  assign port_req[0] = a_req;
  assign port_req[1] = b_req;

  // ------------------------------
  // masked writes
  // ------------------------------
  // Ports are applied in order, so port b lands last on any bit that both
  // ports enable at the same address.
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (port_req[p].write) begin
        for (int i = 0; i < mem2rw_pkg::WIDTH; i++) begin
          if (port_req[p].bw[i]) begin
            mem[port_req[p].addr][i] <= port_req[p].din[i];
          end
        end
      end
    end
  end

  // ------------------------------
  // read delay line
  // ------------------------------
  // the array is sampled before this edge's writes take effect, so a read
  // that meets a write to the same word returns the old contents.
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (port_req[p].read) begin
        rd_pipe[p][0] <= mem[port_req[p].addr];
      end
      for (int d = 1; d < SRAM_DELAY; d++) begin
        rd_pipe[p][d] <= rd_pipe[p][d-1];
      end
    end
  end

  assign a_dout = rd_pipe[0][SRAM_DELAY-1];
  assign b_dout = rd_pipe[1][SRAM_DELAY-1];

  // addresses reaching the array come out of the port pipes.
  for (genvar p = 0; p < 2; p++) begin : g_range
    a_sram_addr_range: assert property (@(posedge clk)
      (port_req[p].read || port_req[p].write) |-> (port_req[p].addr < NUMADDR));
  end

endmodule

// File: mem2rw_pkg.sv
package mem2rw_pkg;

  // ------------------------------
  // word and address geometry
  // ------------------------------
  localparam int WIDTH   = 16;
  localparam int BITADDR = 10;
  localparam int BITWDTH = 4;

  // one access on an external read/write port.
  typedef struct packed {
    logic               read;
    logic               write;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   din;
    logic [WIDTH-1:0]   bw;
  } rw_req_t;

  // read response, vld pulses once per accepted read.
  typedef struct packed {
    logic             vld;
    logic [WIDTH-1:0] dout;
  } rw_rsp_t;

  // access as seen by one SRAM port, after the optional input register.
  typedef struct packed {
    logic               read;
    logic               write;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   din;
    logic [WIDTH-1:0]   bw;
  } sram_req_t;

endpackage
